/* hw/commit_arbiter.sv */
//////////////////////////////////////////////////
// Commit arbiter
// Grants the buffer whose head holds the next
// issue number and drives the commit port
//////////////////////////////////////////////////

`timescale 1ns/1ps

module commit_arbiter (
	input logic clock,
	input logic reset,
	input scalar_pkg::rob_head_t head_s,
	input scalar_pkg::rob_head_t head_v,
	output logic grant_s,
	output logic grant_v,
	output scalar_pkg::commit_t commit
);

	scalar_pkg::issue_no_t next_no;

	assign grant_s = head_s.valid && head_s.done && head_s.issue_no == next_no;
	assign grant_v = head_v.valid && head_v.done && head_v.issue_no == next_no;

	always_ff @(posedge clock) begin
		if (reset) begin
			next_no <= '0;
			commit.valid <= 1'b0;
		end else begin
			commit.valid <= grant_s || grant_v;
			if (grant_s || grant_v) begin
				next_no <= next_no + scalar_pkg::issue_no_t'(1);
			end
		end
		commit.issue_no <= next_no;
		commit.unit <= grant_v;
	end

	// Issue numbers are unique across both buffers
	one_grant: assert property (@(posedge clock) disable iff (reset)
		!(grant_s && grant_v));

endmodule

/* hw/fetch_issue.sv */
//////////////////////////////////////////////////
// Fetch and issue
// Program loading, in-order fetch, issue numbering
// and steering to the scalar or vector backend
//////////////////////////////////////////////////

`timescale 1ns/1ps

module fetch_issue (
	input logic clock,
	input logic reset,
	input logic store_req,
	input scalar_pkg::instr_t store_instr,
	output logic store_ack,
	input logic start,
	output logic mem_we,
	output scalar_pkg::address_t mem_waddr,
	output scalar_pkg::instr_t mem_wdata,
	output scalar_pkg::address_t mem_raddr,
	input scalar_pkg::instr_t mem_rdata,
	input logic full_s,
	input logic full_v,
	output scalar_pkg::issue_t issue_s,
	output scalar_pkg::vcmd_t vcmd,
	output logic store_s,
	output logic store_v,
	output scalar_pkg::issue_no_t store_no,
	output logic term
);

	scalar_pkg::run_state_t state;
	scalar_pkg::address_t pc;
	scalar_pkg::address_t load_ptr;
	scalar_pkg::issue_no_t issue_cnt;
	logic fetch_valid;
	logic running;
	logic target_full;
	logic halt_now;
	logic stall;
	logic do_issue;

	assign running = state == scalar_pkg::st_run;
	assign target_full = mem_rdata.unit ? full_v : full_s;
	assign halt_now = running && fetch_valid && mem_rdata.op == scalar_pkg::op_halt;
	assign stall = running && fetch_valid && !halt_now && target_full;
	assign do_issue = running && fetch_valid && !halt_now && !target_full;

	// Loading goes to consecutive addresses
	assign mem_we = store_req;
	assign mem_waddr = load_ptr;
	assign mem_wdata = store_instr;

	// Re-read the held word while stalled
	assign mem_raddr = stall ? pc - scalar_pkg::address_t'(1) : pc;

	//////////////////////////////////////////////////
	// Steering
	assign issue_s.valid = do_issue && !mem_rdata.unit;
	assign issue_s.issue_no = issue_cnt;
	assign issue_s.instr = mem_rdata;
	assign vcmd.valid = do_issue && mem_rdata.unit;
	assign vcmd.issue_no = issue_cnt;
	assign vcmd.instr = mem_rdata;

	assign store_s = issue_s.valid;
	assign store_v = vcmd.valid;
	assign store_no = issue_cnt;
	assign term = state == scalar_pkg::st_halt;

	//////////////////////////////////////////////////
	// Run control
	always_ff @(posedge clock) begin
		if (reset) begin
			state <= scalar_pkg::st_idle;
			pc <= '0;
			load_ptr <= '0;
			issue_cnt <= '0;
			fetch_valid <= 1'b0;
			store_ack <= 1'b0;
		end else begin
			store_ack <= store_req;
			if (start) begin
				state <= scalar_pkg::st_run;
				pc <= '0;
				load_ptr <= '0;
				issue_cnt <= '0;
				fetch_valid <= 1'b0;
			end else begin
				if (store_req) begin
					load_ptr <= load_ptr + scalar_pkg::address_t'(1);
				end
				if (halt_now) begin
					state <= scalar_pkg::st_halt;
				end
				if (running && !stall && !halt_now) begin
					pc <= pc + scalar_pkg::address_t'(1);
				end
				fetch_valid <= running && !halt_now;
				if (do_issue) begin
					issue_cnt <= issue_cnt + scalar_pkg::issue_no_t'(1);
				end
			end
		end
	end

	// Nothing issues once halted
	halt_blocks_issue: assert property (@(posedge clock) disable iff (reset)
		state == scalar_pkg::st_halt |-> !(issue_s.valid || vcmd.valid));

endmodule

/* hw/instr_mem.sv */
//////////////////////////////////////////////////
// Instruction memory
// One write port for program loading and one
// registered read port for fetch
//////////////////////////////////////////////////

`timescale 1ns/1ps

module instr_mem (
	input logic clock,
	input logic reset,
	input logic we,
	input scalar_pkg::address_t waddr,
	input scalar_pkg::instr_t wdata,
	input scalar_pkg::address_t raddr,
	output scalar_pkg::instr_t rdata
);

	scalar_pkg::instr_t mem [scalar_pkg::IMEM_DEPTH];

	// Program store
	always_ff @(posedge clock) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// Fetch read, one cycle latency
	always_ff @(posedge clock) begin
		if (reset) begin
			rdata <= '0;
		end else begin
			rdata <= mem[raddr];
		end
	end

endmodule

/* hw/reorder_buffer.sv */
//////////////////////////////////////////////////
// Reorder buffer
// Circular list of issue numbers with done bits,
// completed in order and popped on commit grant
//////////////////////////////////////////////////

`timescale 1ns/1ps

module reorder_buffer #(
	parameter int NUM_ENTRY = 4
) (
	input logic clock,
	input logic reset,
	input logic store,
	input scalar_pkg::issue_no_t store_no,
	input logic complete,
	input logic grant,
	output scalar_pkg::rob_head_t head,
	output logic full
);

	localparam int PTR_W = (NUM_ENTRY > 1) ? $clog2(NUM_ENTRY) : 1;
	localparam int CNT_W = $clog2(NUM_ENTRY + 1);

	scalar_pkg::issue_no_t entry_no [NUM_ENTRY];
	logic [NUM_ENTRY-1:0] done;
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] cm_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic [CNT_W-1:0] n_pend;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		next_ptr = (ptr == PTR_W'(NUM_ENTRY - 1)) ? '0 : ptr + PTR_W'(1);
	endfunction

	assign head.valid = count != '0;
	assign head.done = done[rd_ptr];
	assign head.issue_no = entry_no[rd_ptr];
	assign full = count == CNT_W'(NUM_ENTRY);

	// Issue numbers carry no reset
	always_ff @(posedge clock) begin
		if (store) begin
			entry_no[wr_ptr] <= store_no;
		end
	end

	//////////////////////////////////////////////////
	// Pointers and done bits
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			cm_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			n_pend <= '0;
			done <= '0;
		end else begin
			if (store) begin
				wr_ptr <= next_ptr(wr_ptr);
				done[wr_ptr] <= 1'b0;
			end
			// Completion marks the oldest pending entry
			if (complete) begin
				cm_ptr <= next_ptr(cm_ptr);
				done[cm_ptr] <= 1'b1;
			end
			if (grant) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			count <= count + CNT_W'(store) - CNT_W'(grant);
			n_pend <= n_pend + CNT_W'(store) - CNT_W'(complete);
		end
	end

	no_store_when_full: assert property (@(posedge clock) disable iff (reset)
		store |-> !full);
	no_orphan_complete: assert property (@(posedge clock) disable iff (reset)
		complete |-> n_pend != '0);

endmodule

/* hw/scalar_exec.sv */
//////////////////////////////////////////////////
// Scalar backend
// Register file and single ALU stage, result is
// written back one cycle after issue
//////////////////////////////////////////////////

`timescale 1ns/1ps

module scalar_exec (
	input logic clock,
	input logic reset,
	input scalar_pkg::issue_t issue_s,
	output scalar_pkg::wb_t wb
);

	scalar_pkg::data_t regs [scalar_pkg::NUM_REG];
	scalar_pkg::data_t src1_data;
	scalar_pkg::data_t src2_data;
	scalar_pkg::data_t result;

	assign src1_data = regs[issue_s.instr.src1];
	assign src2_data = regs[issue_s.instr.src2];

	// ALU, wraps modulo 2^16
	always_comb begin
		case (issue_s.instr.op)
			scalar_pkg::op_add: result = src1_data + src2_data;
			scalar_pkg::op_sub: result = src1_data - src2_data;
			scalar_pkg::op_xor: result = src1_data ^ src2_data;
			scalar_pkg::op_ldi: result = scalar_pkg::data_t'(issue_s.instr.imm);
			default: result = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Write-back
	always_ff @(posedge clock) begin
		if (reset) begin
			wb.valid <= 1'b0;
			for (int i = 0; i < scalar_pkg::NUM_REG; i++) begin
				regs[i] <= '0;
			end
		end else begin
			wb.valid <= issue_s.valid;
			if (issue_s.valid) begin
				regs[issue_s.instr.dst] <= result;
			end
		end
		wb.dst <= issue_s.instr.dst;
		wb.data <= result;
	end

endmodule

/* hw/scalar_pkg.sv */
//////////////////////////////////////////////////
// Scalar unit package
// Widths, instruction format, opcodes, run states
// and the structs passed between the blocks
//////////////////////////////////////////////////

package scalar_pkg;

	localparam int DATA_W = 16;
	localparam int NUM_REG = 8;
	localparam int ADDR_W = 5;
	localparam int IMEM_DEPTH = 2 ** ADDR_W;
	localparam int ISSUE_W = 4;
	localparam int IMM_W = 8;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [$clog2(NUM_REG)-1:0] reg_idx_t;
	typedef logic [ADDR_W-1:0] address_t;
	typedef logic [ISSUE_W-1:0] issue_no_t;
	typedef logic [IMM_W-1:0] imm_t;

	typedef enum logic [2:0] {
		op_add = 3'd0,
		op_sub = 3'd1,
		op_xor = 3'd2,
		op_ldi = 3'd3,
		op_halt = 3'd4
	} op_t;

	// Unit bit selects the backend, 1 sends it to the vector unit
	typedef struct packed {
		logic unit;
		op_t op;
		reg_idx_t dst;
		reg_idx_t src1;
		reg_idx_t src2;
		imm_t imm;
	} instr_t;

	typedef struct packed {
		logic valid;
		issue_no_t issue_no;
		instr_t instr;
	} issue_t;

	typedef struct packed {
		logic valid;
		issue_no_t issue_no;
		instr_t instr;
	} vcmd_t;

	typedef struct packed {
		logic valid;
		reg_idx_t dst;
		data_t data;
	} wb_t;

	typedef struct packed {
		logic valid;
		issue_no_t issue_no;
		logic unit;
	} commit_t;

	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_run = 2'd1,
		st_halt = 2'd2
	} run_state_t;

	// Oldest entry of a reorder buffer
	typedef struct packed {
		logic valid;
		logic done;
		issue_no_t issue_no;
	} rob_head_t;

endpackage

/* hw/scalar_unit.sv */
//////////////////////////////////////////////////
// Scalar unit top level
// Front end, scalar backend, vector command port
// and in-order commit over two reorder buffers
//////////////////////////////////////////////////

`timescale 1ns/1ps

module scalar_unit #(
	parameter int NUM_ENTRY_S = 4,
	parameter int NUM_ENTRY_V = 4
) (
	input logic clock,
	input logic reset,
	input logic store_req,
	input scalar_pkg::instr_t store_instr,
	output logic store_ack,
	input logic start,
	output scalar_pkg::vcmd_t vcmd,
	input logic vector_done,
	output scalar_pkg::wb_t wb,
	output scalar_pkg::commit_t commit,
	output logic term
);

	logic mem_we;
	scalar_pkg::address_t mem_waddr;
	scalar_pkg::instr_t mem_wdata;
	scalar_pkg::address_t mem_raddr;
	scalar_pkg::instr_t mem_rdata;
	logic full_s;
	logic full_v;
	scalar_pkg::issue_t issue_s;
	logic store_s;
	logic store_v;
	scalar_pkg::issue_no_t store_no;
	scalar_pkg::rob_head_t head_s;
	scalar_pkg::rob_head_t head_v;
	logic grant_s;
	logic grant_v;

	//////////////////////////////////////////////////
	// Front end
	instr_mem i_instr_mem (
		.clock(clock),
		.reset(reset),
		.we(mem_we),
		.waddr(mem_waddr),
		.wdata(mem_wdata),
		.raddr(mem_raddr),
		.rdata(mem_rdata)
	);

	fetch_issue i_fetch_issue (
		.clock(clock),
		.reset(reset),
		.store_req(store_req),
		.store_instr(store_instr),
		.store_ack(store_ack),
		.start(start),
		.mem_we(mem_we),
		.mem_waddr(mem_waddr),
		.mem_wdata(mem_wdata),
		.mem_raddr(mem_raddr),
		.mem_rdata(mem_rdata),
		.full_s(full_s),
		.full_v(full_v),
		.issue_s(issue_s),
		.vcmd(vcmd),
		.store_s(store_s),
		.store_v(store_v),
		.store_no(store_no),
		.term(term)
	);

	scalar_exec i_scalar_exec (
		.clock(clock),
		.reset(reset),
		.issue_s(issue_s),
		.wb(wb)
	);

	//////////////////////////////////////////////////
	// Commit path
	reorder_buffer #(
		.NUM_ENTRY(NUM_ENTRY_S)
	) rob_s (
		.clock(clock),
		.reset(reset),
		.store(store_s),
		.store_no(store_no),
		.complete(wb.valid),
		.grant(grant_s),
		.head(head_s),
		.full(full_s)
	);

	reorder_buffer #(
		.NUM_ENTRY(NUM_ENTRY_V)
	) rob_v (
		.clock(clock),
		.reset(reset),
		.store(store_v),
		.store_no(store_no),
		.complete(vector_done),
		.grant(grant_v),
		.head(head_v),
		.full(full_v)
	);

	commit_arbiter i_commit_arbiter (
		.clock(clock),
		.reset(reset),
		.head_s(head_s),
		.head_v(head_v),
		.grant_s(grant_s),
		.grant_v(grant_v),
		.commit(commit)
	);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f sources.f \
	--top-module tb_scalar_unit -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -q "All tests passed" &&
echo "Simulation PASSED" ||
{ echo "Simulation FAILED"; exit 1; }

/* sources.f */
+incdir+verif
hw/scalar_pkg.sv
hw/instr_mem.sv
hw/fetch_issue.sv
hw/scalar_exec.sv
hw/reorder_buffer.sv
hw/commit_arbiter.sv
hw/scalar_unit.sv
verif/tb_scalar_unit.sv

/* verif/scalar_unit_input.txt */
# P <instr hex>: program word {unit, op, dst, src1, src2, imm}
# W <reg> <data hex>: scalar write-back in order, V <vcmd hex>: vector command in order
P 64005
P 68003
P 105311
P 128822
P 14DB33
P 170044
P 116155
P 13AE66
P 0CA00
P 31100
P 55C00
P 780FF
P 1F500
P 15F877
P 24F00
P 100988
P 08900
P 80000
W 1 0005
W 2 0003
W 3 0008
W 4 FFFE
W 5 FFF6
W 6 00FF
W 7 00F5
W 1 FF10
W 2 FE20
V 2505311
V 2728822
V 294DB33
V 2B70044
V 2D16155
V 2F3AE66
V 3B5F877
V 3F00988

/* verif/scalar_unit_checks.svh */
//////////////////////////////////////////////////
// Compare tasks for the scalar unit testbench
// One task per result kind
//////////////////////////////////////////////////

`ifndef SCALAR_UNIT_CHECKS_SVH
`define SCALAR_UNIT_CHECKS_SVH

task automatic compare_wb(input scalar_pkg::wb_t got, input scalar_pkg::wb_t exp,
		input string what);
	if (got !== exp) begin
		stop_with_failure($sformatf("Error at %0t: %s wb dst %0d data %h, expected dst %0d data %h",
			$time, what, got.dst, got.data, exp.dst, exp.data));
	end
endtask

task automatic compare_vcmd(input scalar_pkg::vcmd_t got, input scalar_pkg::vcmd_t exp,
		input string what);
	if (got !== exp) begin
		stop_with_failure($sformatf("Error at %0t: %s vcmd %h, expected %h",
			$time, what, got, exp));
	end
endtask

task automatic compare_commit(input scalar_pkg::commit_t got, input scalar_pkg::commit_t exp);
	if (got !== exp) begin
		stop_with_failure($sformatf("Error at %0t: commit no %0d unit %0d, expected no %0d unit %0d",
			$time, got.issue_no, got.unit, exp.issue_no, exp.unit));
	end
endtask

`endif

/* verif/tb_scalar_unit.sv */
//////////////////////////////////////////////////
// Scalar unit testbench
// Loads a program from the data file, models the
// vector unit and checks write-back, commands,
// commit order, back-pressure and halt
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_scalar_unit;

	localparam int NUM_ENTRY_V = 4;
	localparam int HOLD_CYCLES = 20;

	logic clock;
	logic reset;
	logic store_req;
	scalar_pkg::instr_t store_instr;
	logic store_ack;
	logic start;
	scalar_pkg::vcmd_t vcmd;
	logic vector_done;
	scalar_pkg::wb_t wb;
	scalar_pkg::commit_t commit;
	logic term;

	scalar_pkg::instr_t prog [32];
	scalar_pkg::wb_t exp_w [32];
	scalar_pkg::vcmd_t exp_v [32];
	scalar_pkg::data_t ref_regs [8];
	int s_idx [32];
	int v_idx [32];
	int n_prog = 0;
	int n_w = 0;
	int n_v = 0;
	int n_s = 0;
	int n_vp = 0;
	int wb_cnt = 0;
	int v_cnt = 0;
	int commit_cnt = 0;
	int v_issued = 0;
	int v_answered = 0;
	int max_outstanding = 0;
	int hold_left = 0;
	int hold_used = 0;
	int v_wait = 0;
	int cycle_cnt = 0;
	int limit = 1000;
	logic req_prev = 1'b0;
	logic term_seen = 1'b0;
	logic [31:0] rng = 32'ha7fa;

	scalar_unit #(
		.NUM_ENTRY_V(NUM_ENTRY_V)
	) i_scalar_unit (
		.clock(clock),
		.reset(reset),
		.store_req(store_req),
		.store_instr(store_instr),
		.store_ack(store_ack),
		.start(start),
		.vcmd(vcmd),
		.vector_done(vector_done),
		.wb(wb),
		.commit(commit),
		.term(term)
	);

	task automatic stop_with_failure(input string msg);
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1);
	endtask

	`include "scalar_unit_checks.svh"

	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Reference ALU with 16-bit wrap
	function automatic scalar_pkg::data_t model_alu(input scalar_pkg::instr_t ins);
		case (ins.op)
			scalar_pkg::op_add: return ref_regs[ins.src1] + ref_regs[ins.src2];
			scalar_pkg::op_sub: return ref_regs[ins.src1] - ref_regs[ins.src2];
			scalar_pkg::op_xor: return ref_regs[ins.src1] ^ ref_regs[ins.src2];
			default: return {8'h00, ins.imm};
		endcase
	endfunction

	task automatic read_input();
		int fd;
		int r;
		int reg_no;
		logic [31:0] val;
		string line;
		fd = $fopen("verif/scalar_unit_input.txt", "r");
		if (fd == 0) begin
			stop_with_failure("Could not open the stimulus file");
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() > 0 && line.getc(0) == "P") begin
				r = $sscanf(line, "P %h", val);
				if (r != 1) begin
					stop_with_failure("Malformed P line in the stimulus file");
				end
				prog[n_prog] = scalar_pkg::instr_t'(val);
				n_prog++;
			end else if (line.len() > 0 && line.getc(0) == "W") begin
				r = $sscanf(line, "W %d %h", reg_no, val);
				if (r != 2) begin
					stop_with_failure("Malformed W line in the stimulus file");
				end
				exp_w[n_w] = {1'b1, scalar_pkg::reg_idx_t'(reg_no), scalar_pkg::data_t'(val)};
				n_w++;
			end else if (line.len() > 0 && line.getc(0) == "V") begin
				r = $sscanf(line, "V %h", val);
				if (r != 1) begin
					stop_with_failure("Malformed V line in the stimulus file");
				end
				exp_v[n_v] = scalar_pkg::vcmd_t'(val);
				n_v++;
			end
		end
		$fclose(fd);
	endtask

	// Program order up to the halt word
	task automatic split_program();
		for (int i = 0; i < n_prog; i++) begin
			if (prog[i].op == scalar_pkg::op_halt) begin
				break;
			end
			if (prog[i].unit) begin
				v_idx[n_vp] = i;
				n_vp++;
			end else begin
				s_idx[n_s] = i;
				n_s++;
			end
		end
	endtask

	always #50 clock = ~clock;

	always @(posedge clock) begin
		cycle_cnt++;
		if (cycle_cnt > limit) begin
			stop_with_failure($sformatf("Run did not finish within %0d cycles", limit));
		end
	end

	////////////////////////////////////////////////
	// Vector unit model
	always @(posedge clock) begin
		if (reset) begin
			vector_done <= 1'b0;
		end else begin
			vector_done <= 1'b0;
			if (hold_used == 0 && v_issued != 0) begin
				hold_used = 1;
				hold_left = HOLD_CYCLES;
			end
			if (hold_left > 0) begin
				hold_left--;
			end else if (v_issued > v_answered) begin
				if (v_wait == 0) begin
					vector_done <= 1'b1;
					v_answered++;
					rng = next_random(rng);
					v_wait = rng[2:0];
				end else begin
					v_wait--;
				end
			end
		end
	end

	////////////////////////////////////////////////
	// Monitors sampled mid-cycle
	always @(negedge clock) begin
		scalar_pkg::wb_t ref_wb;
		scalar_pkg::vcmd_t prog_v;
		scalar_pkg::commit_t exp_c;
		if (!reset) begin
			if (store_ack !== req_prev) begin
				stop_with_failure($sformatf("Error at %0t: store_ack %b after store_req %b",
					$time, store_ack, req_prev));
			end
			if (term_seen && term !== 1'b1) begin
				stop_with_failure("Termination flag dropped before a new start");
			end
			term_seen = term_seen || term === 1'b1;
			if (term && (wb.valid || vcmd.valid)) begin
				stop_with_failure("Write-back or vector command seen after halt");
			end
			if (wb.valid) begin
				if (wb_cnt >= n_s) begin
					stop_with_failure("More scalar write-backs than scalar instructions");
				end
				compare_wb(wb, exp_w[wb_cnt], "W line");
				ref_wb.valid = 1'b1;
				ref_wb.dst = prog[s_idx[wb_cnt]].dst;
				ref_wb.data = model_alu(prog[s_idx[wb_cnt]]);
				ref_regs[ref_wb.dst] = ref_wb.data;
				compare_wb(wb, ref_wb, "reference");
				wb_cnt++;
			end
			if (vcmd.valid) begin
				if (v_cnt >= n_vp) begin
					stop_with_failure("More vector commands than vector instructions");
				end
				compare_vcmd(vcmd, exp_v[v_cnt], "V line");
				prog_v = {1'b1, scalar_pkg::issue_no_t'(v_idx[v_cnt]), prog[v_idx[v_cnt]]};
				compare_vcmd(vcmd, prog_v, "program");
				v_cnt++;
				v_issued++;
			end
			if (commit.valid) begin
				if (commit_cnt >= n_s + n_vp) begin
					stop_with_failure("Commit seen for an instruction that never issued");
				end
				exp_c.valid = 1'b1;
				exp_c.issue_no = scalar_pkg::issue_no_t'(commit_cnt);
				exp_c.unit = prog[commit_cnt].unit;
				compare_commit(commit, exp_c);
				commit_cnt++;
			end
			if (v_issued - v_answered > max_outstanding) begin
				max_outstanding = v_issued - v_answered;
			end
			if (max_outstanding > NUM_ENTRY_V) begin
				stop_with_failure("Vector commands outstanding exceed the buffer depth");
			end
		end
		req_prev = store_req;
	end

	////////////////////////////////////////////////
	// Main sequence
	initial begin
		clock = 1'b0;
		reset = 1'b1;
		store_req = 1'b0;
		store_instr = '0;
		start = 1'b0;
		vector_done = 1'b0;
		for (int i = 0; i < 8; i++) begin
			ref_regs[i] = '0;
		end
		read_input();
		split_program();
		limit = n_prog * 10 + 200;
		if (n_s != n_w || n_vp != n_v) begin
			stop_with_failure("Expected lines do not match the program in the data file");
		end
		rng = next_random(rng);
		v_wait = rng[2:0];
		repeat (4) @(posedge clock);
		reset <= 1'b0;

		// Load the program back to back
		for (int i = 0; i < n_prog; i++) begin
			@(posedge clock);
			store_req <= 1'b1;
			store_instr <= prog[i];
		end
		@(posedge clock);
		store_req <= 1'b0;
		@(posedge clock);
		start <= 1'b1;
		@(posedge clock);
		start <= 1'b0;

		wait (term === 1'b1);
		wait (commit_cnt == n_s + n_vp);
		repeat (10) @(posedge clock);

		if (wb_cnt != n_w || v_cnt != n_v) begin
			stop_with_failure("Write-back or vector command count short at halt");
		end else if (max_outstanding != NUM_ENTRY_V) begin
			stop_with_failure("Back-pressure phase did not fill the vector buffer");
		end else begin
			$display("All tests passed");
			$finish;
		end
	end

endmodule
